// ==== portalCfgPkg.sv ====
package portalCfgPkg;

	// configuration register addresses on the portal config bus
	typedef enum logic [5:0]
	{
		cfgErrCtl  = 6'h38,
		cfgMsgRate = 6'h39,
		cfgPriv    = 6'h3B,
		cfgPso     = 6'h3C
	} cfgAddrT;

	typedef logic [31:0] cfgDataT;
	typedef logic [15:0] taskIdT;
	typedef logic [1:0]  cplT;
	typedef logic [23:0] psoT;
	typedef logic [31:0] portalStateT;

	// register 38h fields
	localparam int soeBit = 21;
	localparam int erBit = 20;
	localparam int errWordMsb = 15;

	// register 39h fields
	localparam int countBaseMsb = 23;
	localparam int countBaseLsb = 16;
	localparam int timerBaseMsb = 15;
	localparam int timerBaseLsb = 0;

	// register 3Bh fields
	localparam int cplMsb = 19;
	localparam int cplLsb = 18;
	localparam int taskIdMsb = 15;
	localparam int taskIdLsb = 0;

endpackage

// ==== portalBusPkg.sv ====
package portalBusPkg;

	// message budget and refill timer
	typedef logic [7:0]  msgCountT;
	typedef logic [15:0] msgTimerT;

	// clock cycles per tick
	localparam int tickPeriod = 16;
	localparam int tickCountWidth = $clog2(tickPeriod);

	typedef logic [tickCountWidth-1:0] tickCountT;

	// last divider value before the tick fires
	localparam tickCountT tickLast = tickCountT'(tickPeriod - 1);

	// error code as reported by the memory channel
	typedef logic [63:0] errCodeT;

endpackage

// ==== cfgIf.sv ====
`timescale 1ns/10ps

interface cfgIf
	import portalCfgPkg::*;
();

	logic cfgStb;
	logic cfgRst;
	cfgAddrT cfgAddr;
	cfgDataT cfgData;

	// driven by the context controller side
	modport source
	(
		output cfgStb,
		output cfgRst,
		output cfgAddr,
		output cfgData
	);

	modport sink
	(
		input cfgStb,
		input cfgRst,
		input cfgAddr,
		input cfgData
	);

endinterface

// ==== portalRegs.sv ====
`timescale 1ns/10ps

module portalRegs
	import portalCfgPkg::*;
	import portalBusPkg::*;
(
	input logic CLK50,
	input logic RST,
	cfgIf.sink cfg,
	input logic portalReady,
	input logic portalActivation,
	input taskIdT csrTaskId,
	input cplT csrCpl,
	input psoT cpsr,
	output msgCountT countBase,
	output msgTimerT timerBase,
	output logic cfgRst,
	output logic soeFlag,
	output logic erFlag,
	output taskIdT taskId,
	output cplT cpl,
	output psoT pso,
	output portalStateT portalState
);

	logic wrErrCtl;
	logic wrMsgRate;
	logic wrPriv;
	logic wrPso;
	logic activate;
	logic [errWordMsb:0] errCtlWord;

	// write decode
	assign wrErrCtl = cfg.cfgStb && (cfg.cfgAddr == cfgErrCtl);
	assign wrMsgRate = cfg.cfgStb && (cfg.cfgAddr == cfgMsgRate);
	assign wrPriv = cfg.cfgStb && (cfg.cfgAddr == cfgPriv);
	assign wrPso = cfg.cfgStb && (cfg.cfgAddr == cfgPso);
	assign activate = portalReady && portalActivation;

	// message settings clear strobe goes on to the limiter
	assign cfgRst = cfg.cfgRst;

	// ====================
	// register 38h and 39h
	always_ff @(posedge CLK50)
	begin
		if (!RST)
		begin
			soeFlag <= 1'b0;
			erFlag <= 1'b1;
			errCtlWord <= '0;
		end
		else if (wrErrCtl)
		begin
			soeFlag <= cfg.cfgData[soeBit];
			erFlag <= cfg.cfgData[erBit];
			errCtlWord <= cfg.cfgData[errWordMsb:0];
		end
	end

	always_ff @(posedge CLK50)
	begin
		if (!RST || cfg.cfgRst)
		begin
			countBase <= '0;
			timerBase <= '0;
		end
		else if (wrMsgRate)
		begin
			countBase <= cfg.cfgData[countBaseMsb:countBaseLsb];
			timerBase <= cfg.cfgData[timerBaseMsb:timerBaseLsb];
		end
	end

	// ====================
	// config write beats activation for the portal parameters
	always_ff @(posedge CLK50)
	begin
		if (!RST)
		begin
			cpl <= '0;
			taskId <= '0;
			pso <= '0;
		end
		else
		begin
			if (wrPriv)
			begin
				cpl <= cfg.cfgData[cplMsb:cplLsb];
				taskId <= cfg.cfgData[taskIdMsb:taskIdLsb];
			end
			else if (activate)
			begin
				cpl <= csrCpl;
				taskId <= csrTaskId;
			end
			if (wrPso)
				pso <= psoT'(cfg.cfgData);
			else if (activate)
				pso <= cpsr;
		end
	end

	// readback follows the address with or without a strobe
	always_ff @(posedge CLK50)
	begin
		if (!RST)
			portalState <= '0;
		else
		begin
			case (cfg.cfgAddr)
				cfgPso: portalState <= portalStateT'(pso);
				cfgPriv: portalState <= {12'd0, cpl, 2'd0, taskId};
				default: portalState <= portalStateT'(errCtlWord);
			endcase
		end
	end

endmodule

// ==== msgRateLimiter.sv ====
`timescale 1ns/10ps

module msgRateLimiter
	import portalBusPkg::*;
(
	input logic CLK50,
	input logic RST,
	input logic cfgRst,
	input logic portalSMsg,
	input msgCountT countBase,
	input msgTimerT timerBase,
	output logic msgAccept,
	output logic tick
);

	tickCountT tickCnt;
	msgCountT msgCnt;
	msgTimerT msgTimer;
	logic msgEnable;
	logic timerDone;

	// ====================
	// tick divider
	always_ff @(posedge CLK50)
	begin
		if (!RST)
		begin
			tickCnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tickCnt <= (tickCnt == tickLast) ? '0 : tickCnt + 1'b1;
			tick <= (tickCnt == tickLast);
		end
	end

	// ====================
	// budget and refill timer
	assign timerDone = (msgTimer == '0);

	// grant only while budget remains
	assign msgAccept = portalSMsg && msgEnable && (msgCnt != '0);

	always_ff @(posedge CLK50)
	begin
		if (!RST || cfgRst)
		begin
			msgCnt <= '0;
			msgTimer <= '0;
		end
		else
		begin
			if (timerDone)
				msgCnt <= countBase;
			else if (msgAccept)
				msgCnt <= msgCnt - 1'b1;

			// timer only runs once the budget has been touched
			if (timerDone)
				msgTimer <= timerBase;
			else if (tick && (msgCnt != countBase))
				msgTimer <= msgTimer - 1'b1;
		end
	end

	always_ff @(posedge CLK50)
	begin
		if (!RST)
			msgEnable <= 1'b0;
		else
			msgEnable <= (msgCnt != '0);
	end

endmodule

// ==== errorGuard.sv ====
`timescale 1ns/10ps

module errorGuard
	import portalBusPkg::*;
(
	input logic CLK50,
	input logic RST,
	input logic soeFlag,
	input logic erFlag,
	input logic errStb,
	input logic portalRun,
	input errCodeT errCode,
	output logic errorLock,
	output logic errReport,
	output logic portalRst,
	output errCodeT errCodeOut
);

	logic stopHit;
	logic reportHit;

	assign stopHit = errStb && soeFlag;
	assign reportHit = errStb && erFlag;

	// lock holds until the context controller restarts the portal
	always_ff @(posedge CLK50)
	begin
		if (!RST)
		begin
			errorLock <= 1'b0;
			errReport <= 1'b0;
			portalRst <= 1'b1;
		end
		else
		begin
			errorLock <= (errorLock || stopHit) && !portalRun;
			errReport <= reportHit;
			portalRst <= !stopHit;
		end
	end

	always_ff @(posedge CLK50)
	begin
		if (reportHit)
			errCodeOut <= errCode;
	end

endmodule

// ==== portalControl.sv ====
`timescale 1ns/10ps

module portalControl
	import portalCfgPkg::*;
	import portalBusPkg::*;
(
	input logic CLK50,
	input logic RST,
	// config bus
	input logic cfgStb,
	input logic cfgRst,
	input cfgAddrT cfgAddr,
	input cfgDataT cfgData,
	// activation from the core
	input logic portalReady,
	input logic portalActivation,
	input taskIdT csrTaskId,
	input cplT csrCpl,
	input psoT cpsr,
	// messages and errors
	input logic portalSMsg,
	input logic portalRun,
	input logic errStb,
	input errCodeT errCode,
	output logic msgAccept,
	output logic tick,
	output logic errorLock,
	output logic errReport,
	output errCodeT errCodeOut,
	output logic portalRst,
	// captured parameters and readback
	output taskIdT taskId,
	output cplT cpl,
	output psoT pso,
	output portalStateT portalState
);

	msgCountT countBase;
	msgTimerT timerBase;
	logic msgCfgRst;
	logic soeFlag;
	logic erFlag;

	cfgIf cfgBus ();

	assign cfgBus.cfgStb = cfgStb;
	assign cfgBus.cfgRst = cfgRst;
	assign cfgBus.cfgAddr = cfgAddr;
	assign cfgBus.cfgData = cfgData;

	portalRegs portalRegs_i
	(
		.CLK50(CLK50), .RST(RST), .cfg(cfgBus.sink),
		.portalReady(portalReady), .portalActivation(portalActivation),
		.csrTaskId(csrTaskId), .csrCpl(csrCpl), .cpsr(cpsr),
		.countBase(countBase), .timerBase(timerBase), .cfgRst(msgCfgRst),
		.soeFlag(soeFlag), .erFlag(erFlag),
		.taskId(taskId), .cpl(cpl), .pso(pso), .portalState(portalState)
	);

	msgRateLimiter msgRateLimiter_i
	(
		.CLK50(CLK50), .RST(RST), .cfgRst(msgCfgRst), .portalSMsg(portalSMsg),
		.countBase(countBase), .timerBase(timerBase),
		.msgAccept(msgAccept), .tick(tick)
	);

	errorGuard errorGuard_i
	(
		.CLK50(CLK50), .RST(RST), .soeFlag(soeFlag), .erFlag(erFlag),
		.errStb(errStb), .portalRun(portalRun), .errCode(errCode),
		.errorLock(errorLock), .errReport(errReport), .portalRst(portalRst),
		.errCodeOut(errCodeOut)
	);

endmodule

// ==== tbPortalControl.sv ====
`timescale 1ns/10ps

module tbPortalControl
	import portalCfgPkg::*;
	import portalBusPkg::*;
();

	// one table row holds a write phase and a readback phase
	typedef struct packed
	{
		logic stb;
		cfgAddrT addr;
		cfgDataT data;
		logic act;
		taskIdT csrTask;
		cplT csrCplV;
		psoT cpsrV;
		cfgAddrT rdAddr;
		portalStateT expected;
	} rowT;

	logic CLK50;
	logic RST;
	logic cfgStb;
	logic cfgRst;
	cfgAddrT cfgAddr;
	cfgDataT cfgData;
	logic portalReady;
	logic portalActivation;
	taskIdT csrTaskId;
	cplT csrCpl;
	psoT cpsr;
	logic portalSMsg;
	logic portalRun;
	logic errStb;
	errCodeT errCode;
	logic msgAccept;
	logic tick;
	logic errorLock;
	logic errReport;
	errCodeT errCodeOut;
	logic portalRst;
	taskIdT taskId;
	cplT cpl;
	psoT pso;
	portalStateT portalState;

	integer seed;
	integer valueErrors;
	integer timeoutErrors;
	rowT rows [0:7];

	portalControl portalControl_i
	(
		.CLK50(CLK50), .RST(RST), .cfgStb(cfgStb), .cfgRst(cfgRst),
		.cfgAddr(cfgAddr), .cfgData(cfgData),
		.portalReady(portalReady), .portalActivation(portalActivation),
		.csrTaskId(csrTaskId), .csrCpl(csrCpl), .cpsr(cpsr),
		.portalSMsg(portalSMsg), .portalRun(portalRun), .errStb(errStb), .errCode(errCode),
		.msgAccept(msgAccept), .tick(tick), .errorLock(errorLock), .errReport(errReport),
		.errCodeOut(errCodeOut), .portalRst(portalRst),
		.taskId(taskId), .cpl(cpl), .pso(pso), .portalState(portalState)
	);

	always #20 CLK50 = ~CLK50;

	// ====================
	// compare tasks
	task automatic checkState(input string name, input portalStateT expected,
		input portalStateT actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			valueErrors = valueErrors + 1;
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected %b, actual %b", name, expected, actual);
			valueErrors = valueErrors + 1;
		end
	endtask

	task automatic checkCount(input string name, input msgCountT expected,
		input msgCountT actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
			valueErrors = valueErrors + 1;
		end
	endtask

	task automatic checkCode(input string name, input errCodeT expected, input errCodeT actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			valueErrors = valueErrors + 1;
		end
	endtask

	task automatic checkParams(input string name, input taskIdT expTask, input cplT expCpl,
		input psoT expPso, input taskIdT actTask, input cplT actCpl, input psoT actPso);
		if (actTask !== expTask || actCpl !== expCpl || actPso !== expPso)
		begin
			$display("** Error %s: expected %h/%h/%h, actual %h/%h/%h", name,
				expTask, expCpl, expPso, actTask, actCpl, actPso);
			valueErrors = valueErrors + 1;
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout: %s", what);
		timeoutErrors = timeoutErrors + 1;
	endtask

	// ====================
	// drive helpers
	task automatic nextDriveSlot();
		@(posedge CLK50);
		#2;
	endtask

	task automatic writeConfig(input cfgAddrT addr, input cfgDataT data);
		nextDriveSlot();
		cfgStb = 1'b1;
		cfgAddr = addr;
		cfgData = data;
		nextDriveSlot();
		cfgStb = 1'b0;
	endtask

	task automatic pulseError(input errCodeT code);
		nextDriveSlot();
		errStb = 1'b1;
		errCode = code;
		nextDriveSlot();
		errStb = 1'b0;
	endtask

	// counts grants over a fixed window of cycles
	task automatic countAccepts(input int cycles, output msgCountT accepts);
		accepts = '0;
		repeat (cycles)
		begin
			@(negedge CLK50);
			if (msgAccept)
				accepts = accepts + 1'b1;
		end
	endtask

	// expected readback follows the address mapping of the register map
	task automatic buildTable();
		logic [31:0] d0;
		logic [31:0] d1;
		logic [31:0] d2;
		logic [31:0] d5;
		logic [31:0] r3;
		logic [31:0] p3;
		logic [31:0] r5;
		logic [31:0] p5;
		d0 = $random(seed);
		d1 = $random(seed);
		d2 = $random(seed);
		d5 = $random(seed);
		r3 = $random(seed);
		p3 = $random(seed);
		r5 = $random(seed);
		p5 = $random(seed);
		rows[0] = '{1'b1, cfgErrCtl, d0, 1'b0, 16'd0, 2'd0, 24'd0, cfgErrCtl,
			{16'd0, d0[15:0]}};
		rows[1] = '{1'b1, cfgPriv, d1, 1'b0, 16'd0, 2'd0, 24'd0, cfgPriv,
			{12'd0, d1[19:18], 2'd0, d1[15:0]}};
		rows[2] = '{1'b1, cfgPso, d2, 1'b0, 16'd0, 2'd0, 24'd0, cfgPso, {8'd0, d2[23:0]}};
		// activation alone
		rows[3] = '{1'b0, cfgErrCtl, 32'd0, 1'b1, r3[15:0], r3[17:16], p3[23:0], cfgPriv,
			{12'd0, r3[17:16], 2'd0, r3[15:0]}};
		rows[4] = '{1'b0, cfgErrCtl, 32'd0, 1'b0, 16'd0, 2'd0, 24'd0, cfgPso, {8'd0, p3[23:0]}};
		// strobe to 3Bh wins over activation while the selector is still captured
		rows[5] = '{1'b1, cfgPriv, d5, 1'b1, r5[15:0], r5[17:16], p5[23:0], cfgPriv,
			{12'd0, d5[19:18], 2'd0, d5[15:0]}};
		rows[6] = '{1'b0, cfgErrCtl, 32'd0, 1'b0, 16'd0, 2'd0, 24'd0, cfgErrCtl,
			{16'd0, d0[15:0]}};
		rows[7] = '{1'b0, cfgErrCtl, 32'd0, 1'b0, 16'd0, 2'd0, 24'd0, cfgPso, {8'd0, p5[23:0]}};
	endtask

	// ====================
	initial
	begin
		msgCountT accepts;
		errCodeT firstCode;
		logic sawReport;
		logic [31:0] r;
		int waited;
		seed = 32'h56f6092b;
		valueErrors = 0;
		timeoutErrors = 0;
		CLK50 = 1'b0;
		RST = 1'b0;
		cfgStb = 1'b0;
		cfgRst = 1'b0;
		cfgAddr = cfgErrCtl;
		cfgData = '0;
		portalReady = 1'b0;
		portalActivation = 1'b0;
		csrTaskId = '0;
		csrCpl = '0;
		cpsr = '0;
		portalSMsg = 1'b0;
		portalRun = 1'b0;
		errStb = 1'b0;
		errCode = '0;
		buildTable();
		repeat (2) @(posedge CLK50);
		#2;
		RST = 1'b1;

		// reset state
		@(posedge CLK50);
		@(negedge CLK50);
		checkState("reset readback", 32'd0, portalState);
		checkFlag("reset errorLock", 1'b0, errorLock);
		checkFlag("reset errReport", 1'b0, errReport);
		checkFlag("reset portalRst", 1'b1, portalRst);
		checkFlag("reset tick", 1'b0, tick);
		nextDriveSlot();
		portalSMsg = 1'b1;
		countAccepts(50, accepts);
		checkCount("reset msgAccept", 8'd0, accepts);
		portalSMsg = 1'b0;

		// tick is a single-cycle pulse every tickPeriod cycles
		waited = 0;
		@(negedge CLK50);
		while (tick !== 1'b1 && waited < 2 * tickPeriod)
		begin
			@(negedge CLK50);
			waited++;
		end
		if (tick !== 1'b1)
			reportTimeout("tick never pulsed");
		for (int k = 1; k <= tickPeriod; k++)
		begin
			@(negedge CLK50);
			checkFlag($sformatf("tick cycle %0d", k), k == tickPeriod, tick);
		end

		// register table
		for (int i = 0; i < 8; i++)
		begin
			nextDriveSlot();
			cfgStb = rows[i].stb;
			cfgAddr = rows[i].addr;
			cfgData = rows[i].data;
			portalReady = rows[i].act;
			portalActivation = rows[i].act;
			csrTaskId = rows[i].csrTask;
			csrCpl = rows[i].csrCplV;
			cpsr = rows[i].cpsrV;
			nextDriveSlot();
			cfgStb = 1'b0;
			portalReady = 1'b0;
			portalActivation = 1'b0;
			cfgAddr = rows[i].rdAddr;
			@(posedge CLK50);
			@(negedge CLK50);
			checkState($sformatf("table row %0d", i), rows[i].expected, portalState);
		end
		// last strobe to 3Bh and last captured selector on the direct outputs
		checkParams("portal parameters", rows[5].data[15:0], rows[5].data[19:18],
			rows[5].cpsrV, taskId, cpl, pso);

		// budget of 3 with the refill far beyond the window
		writeConfig(cfgMsgRate, {8'd0, 8'd3, 16'd100});
		portalSMsg = 1'b1;
		countAccepts(200, accepts);
		checkCount("msg budget", 8'd3, accepts);
		nextDriveSlot();
		cfgRst = 1'b1;
		nextDriveSlot();
		cfgRst = 1'b0;
		// the refill would land inside this window without the cfgRst
		countAccepts(100 * tickPeriod + 100, accepts);
		checkCount("msg after cfgRst", 8'd0, accepts);
		portalSMsg = 1'b0;

		// ====================
		// error guard with stop-on-error and reporting on
		r = $random(seed);
		writeConfig(cfgErrCtl, {10'd0, 1'b1, 1'b1, 4'd0, r[15:0]});
		firstCode = {$random(seed), $random(seed)};
		pulseError(firstCode);
		waited = 0;
		@(negedge CLK50);
		while (errorLock !== 1'b1 && waited < 8)
		begin
			@(negedge CLK50);
			waited++;
		end
		if (errorLock !== 1'b1)
			reportTimeout("errorLock never rose after errStb");
		checkFlag("portalRst pulse", 1'b0, portalRst);
		checkFlag("errReport on", 1'b1, errReport);
		checkCode("errCodeOut", firstCode, errCodeOut);
		@(negedge CLK50);
		checkFlag("portalRst released", 1'b1, portalRst);
		checkFlag("errReport single", 1'b0, errReport);
		checkFlag("lock held", 1'b1, errorLock);
		nextDriveSlot();
		portalRun = 1'b1;
		nextDriveSlot();
		portalRun = 1'b0;
		waited = 0;
		while (errorLock !== 1'b0 && waited < 8)
		begin
			@(negedge CLK50);
			waited++;
		end
		if (errorLock !== 1'b0)
			reportTimeout("portalRun did not clear errorLock");

		// reporting masked
		writeConfig(cfgErrCtl, {10'd0, 1'b1, 1'b0, 4'd0, r[15:0]});
		pulseError({$random(seed), $random(seed)});
		sawReport = 1'b0;
		repeat (3)
		begin
			@(negedge CLK50);
			sawReport = sawReport | errReport;
		end
		checkFlag("errReport masked", 1'b0, sawReport);
		checkCode("errCodeOut held", firstCode, errCodeOut);

		$display("errors: %0d value mismatches, %0d timeouts", valueErrors, timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
portalCfgPkg.sv
portalBusPkg.sv
cfgIf.sv
portalRegs.sv
msgRateLimiter.sv
errorGuard.sv
portalControl.sv
tbPortalControl.sv

// ==== Makefile ====
TOP = tbPortalControl

all: run

compile:
	verilator --binary --timing --timescale 1ns/10ps -f verilog.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
